//--- hdl/cadr_pkg.sv
// Datapath widths, microinstruction field positions, opcode/ALU/jump/state enums
`default_nettype none

package cadr_pkg;

   //////////////////////////////
   // Widths
   //////////////////////////////
   parameter int DATA_W  = 32;              // Datapath word
   parameter int UPC_W   = 8;               // Default micro-PC width
   parameter int AMEM_AW = 6;               // 64 A-memory words
   parameter int MMEM_AW = 5;               // 32 M-memory words
   parameter int UINST_W = 40;              // Control memory word
   parameter int SHIFT_W = 5;               // Rotate count and mask width fields

   //////////////////////////////
   // Microinstruction layout
   //////////////////////////////
   parameter int OP_LO       = 0;
   parameter int OP_HI       = 1;
   parameter int ALUF_LO     = 2;
   parameter int ALUF_HI     = 4;
   parameter int JCOND_LO    = 5;
   parameter int JCOND_HI    = 6;
   parameter int M_IS_MD_BIT = 7;           // M source is md, not M-memory
   parameter int MADR_LO     = 8;
   parameter int MADR_HI     = 12;
   parameter int AADR_LO     = 13;
   parameter int AADR_HI     = 18;
   parameter int DEST_M_BIT  = 19;          // Write M-memory too
   parameter int DEST_LO     = 20;
   parameter int DEST_HI     = 25;
   parameter int ROT_LO      = 26;
   parameter int ROT_HI      = 30;
   parameter int WIDTH_LO    = 31;          // Byte width minus 1
   parameter int WIDTH_HI    = 35;
   parameter int JUMP_LO     = 20;          // Jump target overlays DEST and ROT
   parameter int JUMP_HI     = 30;
   parameter int JUMP_W      = JUMP_HI - JUMP_LO + 1;

   //////////////////////////////
   // Enums
   //////////////////////////////
   typedef enum logic [1:0] {
      OP_ALU  = 2'd0,
      OP_BYTE = 2'd1,                       // Rotate and mask
      OP_JUMP = 2'd2,
      OP_NOP  = 2'd3
   } uop_t;

   typedef enum logic [2:0] {
      ALU_ADD  = 3'd0,
      ALU_SUB  = 3'd1,                      // a minus m
      ALU_AND  = 3'd2,
      ALU_OR   = 3'd3,
      ALU_XOR  = 3'd4,
      ALU_SETA = 3'd5,
      ALU_SETM = 3'd6,
      ALU_INCM = 3'd7
   } aluf_t;

   typedef enum logic [1:0] {
      J_ALWAYS = 2'd0,
      J_EQ     = 2'd1,                      // a equals m
      J_LT     = 2'd2,                      // a below m, unsigned
      J_NEVER  = 2'd3
   } jcond_t;

   typedef enum logic [2:0] {
      ST_RESET  = 3'd0,
      ST_DECODE = 3'd1,
      ST_READ   = 3'd2,
      ST_ALU    = 3'd3,
      ST_WRITE  = 3'd4,
      ST_FETCH  = 3'd5
   } mstate_t;

endpackage

`default_nettype wire

//--- hdl/cadr_micro_if.sv
// Decoded microinstruction field bundle with producer and consumer modports
`timescale 1ns/1ps
`default_nettype none

interface cadr_micro_if;
   cadr_pkg::uop_t                   op;           // Instruction class
   cadr_pkg::aluf_t                  aluf;
   cadr_pkg::jcond_t                 jcond;
   logic                             m_is_md;      // Take M from md
   logic [cadr_pkg::AMEM_AW-1:0]     aadr;         // A source
   logic [cadr_pkg::MMEM_AW-1:0]     madr;         // M source
   logic [cadr_pkg::AMEM_AW-1:0]     dest;
   logic                             dest_m;       // Also write M-memory
   logic [cadr_pkg::SHIFT_W-1:0]     rot;          // Left rotate count
   logic [cadr_pkg::SHIFT_W-1:0]     width;        // Mask width minus 1
   logic [cadr_pkg::JUMP_W-1:0]      jump_target;  // Zero above micro-PC width

   modport producer (
      output op, aluf, jcond, m_is_md, aadr, madr, dest, dest_m, rot, width,
             jump_target
   );

   modport consumer (
      input  op, aluf, jcond, m_is_md, aadr, madr, dest, dest_m, rot, width,
             jump_target
   );
endinterface

`default_nettype wire

//--- hdl/cadr_wb_if.sv
// Scratchpad read address/data and write-back bundle between execute and writeback
`timescale 1ns/1ps
`default_nettype none

interface cadr_wb_if;
   // Read side, data one cycle after address
   logic [cadr_pkg::AMEM_AW-1:0]  rd_aadr;
   logic [cadr_pkg::MMEM_AW-1:0]  rd_madr;
   logic [cadr_pkg::DATA_W-1:0]   a_data;
   logic [cadr_pkg::DATA_W-1:0]   m_data;

   // Write side, single-cycle pulse in WRITE
   logic                          wr_en;
   logic [cadr_pkg::AMEM_AW-1:0]  wr_dest;
   logic                          wr_dest_m;     // M write, mirrored into A
   logic [cadr_pkg::DATA_W-1:0]   wr_data;

   modport execute (
      output rd_aadr, rd_madr, wr_en, wr_dest, wr_dest_m, wr_data,
      input  a_data, m_data
   );

   modport store (
      input  rd_aadr, rd_madr, wr_en, wr_dest, wr_dest_m, wr_data,
      output a_data, m_data
   );
endinterface

`default_nettype wire

//--- hdl/cadr_sequencer.sv
// Machine-state FSM, micro-PC and writable control memory
`timescale 1ns/1ps
`default_nettype none

module cadr_sequencer #(
   parameter int UPC_W = cadr_pkg::UPC_W
) (
   input  wire logic                         clk,
   input  wire logic                         reset,
   input  wire logic                         run,          // Level, sampled in DECODE
   input  wire logic                         load_en,      // Control memory write strobe
   input  wire logic [UPC_W-1:0]             load_addr,
   input  wire logic [cadr_pkg::UINST_W-1:0] load_data,
   input  wire logic                         jump_taken,   // From execute, held through FETCH
   input  wire logic [UPC_W-1:0]             jump_target,
   output cadr_pkg::mstate_t                 state,
   output logic [cadr_pkg::UINST_W-1:0]      uinst,        // Word for the IR
   output logic [UPC_W-1:0]                  upc
);

   logic [cadr_pkg::UINST_W-1:0] ctl_mem [0:2**UPC_W-1];   // Writable control store
   cadr_pkg::mstate_t            state_nxt;
   logic [UPC_W-1:0]             upc_nxt;
   logic                         primed;                   // First fetch done

   //////////////////////////////
   // State machine
   //////////////////////////////
   always_comb begin
      case (state)
         cadr_pkg::ST_RESET:  state_nxt = cadr_pkg::ST_DECODE;
         cadr_pkg::ST_DECODE: state_nxt = run ? cadr_pkg::ST_READ : cadr_pkg::ST_DECODE;
         cadr_pkg::ST_READ:   state_nxt = cadr_pkg::ST_ALU;
         cadr_pkg::ST_ALU:    state_nxt = cadr_pkg::ST_WRITE;
         cadr_pkg::ST_WRITE:  state_nxt = cadr_pkg::ST_FETCH;
         default:             state_nxt = cadr_pkg::ST_DECODE;  // FETCH wraps round
      endcase
   end

   //////////////////////////////
   // Micro-PC
   //////////////////////////////
   // The IR comes up as a NOP, so the first fetch after reset
   // takes word 0 and leaves the micro-PC where it is
   always_comb begin
      if (!primed) begin
         upc_nxt = upc;
      end else if (jump_taken) begin
         upc_nxt = jump_target;
      end else begin
         upc_nxt = upc + 1'b1;                             // Wraps
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state  <= cadr_pkg::ST_RESET;
         upc    <= '0;
         primed <= 1'b0;
      end else begin
         state <= state_nxt;
         if (state == cadr_pkg::ST_FETCH) begin
            upc    <= upc_nxt;                             // Micro-PC tracks the IR
            primed <= 1'b1;
         end
      end
   end

   //////////////////////////////
   // Control memory
   //////////////////////////////
   always_ff @(posedge clk) begin
      if (load_en) begin
         ctl_mem[load_addr] <= load_data;                  // Load port, any cycle
      end
   end

   // Read at the next micro-PC, IR captures it at end of FETCH
   assign uinst = ctl_mem[upc_nxt];

endmodule

`default_nettype wire

//--- hdl/cadr_decode.sv
// Instruction register and microinstruction field decode
`timescale 1ns/1ps
`default_nettype none

module cadr_decode #(
   parameter int UPC_W = cadr_pkg::UPC_W
) (
   input  wire logic                         clk,
   input  wire logic                         reset,
   input  wire cadr_pkg::mstate_t            state,
   input  wire logic [cadr_pkg::UINST_W-1:0] uinst,   // Control memory word
   cadr_micro_if.producer                    mi
);

   logic [cadr_pkg::UINST_W-1:0] ir;                  // Instruction register

   //////////////////////////////
   // Instruction register
   //////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         ir                                <= '0;
         ir[cadr_pkg::OP_HI:cadr_pkg::OP_LO] <= cadr_pkg::OP_NOP;  // Idle word
      end else if (state == cadr_pkg::ST_FETCH) begin
         ir <= uinst;                                 // Held until next FETCH
      end
   end

   //////////////////////////////
   // Field slicing
   //////////////////////////////
   always_comb begin
      mi.op      = cadr_pkg::uop_t'(ir[cadr_pkg::OP_HI:cadr_pkg::OP_LO]);
      mi.aluf    = cadr_pkg::aluf_t'(ir[cadr_pkg::ALUF_HI:cadr_pkg::ALUF_LO]);
      mi.jcond   = cadr_pkg::jcond_t'(ir[cadr_pkg::JCOND_HI:cadr_pkg::JCOND_LO]);
      mi.m_is_md = ir[cadr_pkg::M_IS_MD_BIT];
   end

   // Scratchpad addresses, stable from READ onward
   always_comb begin
      mi.madr   = ir[cadr_pkg::MADR_HI:cadr_pkg::MADR_LO];
      mi.aadr   = ir[cadr_pkg::AADR_HI:cadr_pkg::AADR_LO];
      mi.dest   = ir[cadr_pkg::DEST_HI:cadr_pkg::DEST_LO];
      mi.dest_m = ir[cadr_pkg::DEST_M_BIT];
   end

   // Byte extract controls
   always_comb begin
      mi.rot   = ir[cadr_pkg::ROT_HI:cadr_pkg::ROT_LO];
      mi.width = ir[cadr_pkg::WIDTH_HI:cadr_pkg::WIDTH_LO];
   end

   // Jump target, low micro-PC bits of the DEST/ROT overlay
   always_comb begin
      mi.jump_target = {{(cadr_pkg::JUMP_W - UPC_W){1'b0}},
                        ir[cadr_pkg::JUMP_LO +: UPC_W]};
   end

endmodule

`default_nettype wire

//--- hdl/cadr_execute.sv
// M-source select, ALU, rotator, mask generator, output bus and jump condition
`timescale 1ns/1ps
`default_nettype none

module cadr_execute (
   input  wire logic                        clk,
   input  wire logic                        reset,
   input  wire cadr_pkg::mstate_t           state,
   input  wire logic [cadr_pkg::DATA_W-1:0] md,          // External memory data
   cadr_micro_if.consumer                   mi,
   cadr_wb_if.execute                       wb,
   output logic                             jump_taken,  // Valid from WRITE
   output logic                             obs_valid,
   output logic [cadr_pkg::AMEM_AW-1:0]     obs_dest,
   output logic                             obs_dest_m,
   output logic [cadr_pkg::DATA_W-1:0]      obs_data
);

   logic                        st_alu;                  // Phase strobes
   logic                        st_write;
   logic [cadr_pkg::DATA_W-1:0] m_val;
   logic [cadr_pkg::DATA_W-1:0] alu_out;
   logic [2*cadr_pkg::DATA_W-1:0] rot_dbl;
   logic [cadr_pkg::DATA_W-1:0] msk;
   logic [cadr_pkg::DATA_W-1:0] ob;                     // Output bus
   logic [cadr_pkg::DATA_W-1:0] ob_q;                   // Result latched in ALU
   logic                        cond;
   logic                        do_write;

   assign st_alu   = (state == cadr_pkg::ST_ALU);
   assign st_write = (state == cadr_pkg::ST_WRITE);

   // Read addresses straight from the IR fields
   assign wb.rd_aadr = mi.aadr;
   assign wb.rd_madr = mi.madr;

   assign m_val = mi.m_is_md ? md : wb.m_data;         // M latch source

   //////////////////////////////
   // ALU
   //////////////////////////////
   always_comb begin
      case (mi.aluf)
         cadr_pkg::ALU_ADD:  alu_out = wb.a_data + m_val;
         cadr_pkg::ALU_SUB:  alu_out = wb.a_data - m_val;
         cadr_pkg::ALU_AND:  alu_out = wb.a_data & m_val;
         cadr_pkg::ALU_OR:   alu_out = wb.a_data | m_val;
         cadr_pkg::ALU_XOR:  alu_out = wb.a_data ^ m_val;
         cadr_pkg::ALU_SETA: alu_out = wb.a_data;
         cadr_pkg::ALU_SETM: alu_out = m_val;
         default:            alu_out = m_val + 1'b1;     // INCM
      endcase
   end

   //////////////////////////////
   // Rotator and mask
   //////////////////////////////
   // Upper half of the doubled word is M rotated left
   assign rot_dbl = {m_val, m_val} << mi.rot;

   always_comb begin
      for (int i = 0; i < cadr_pkg::DATA_W; i++) begin
         msk[i] = (i <= int'(mi.width));                 // Low width+1 bits
      end
   end

   assign ob = (mi.op == cadr_pkg::OP_BYTE) ?
               (rot_dbl[2*cadr_pkg::DATA_W-1:cadr_pkg::DATA_W] & msk) : alu_out;

   // Jump condition on the same A and M
   always_comb begin
      case (mi.jcond)
         cadr_pkg::J_ALWAYS: cond = 1'b1;
         cadr_pkg::J_EQ:     cond = (wb.a_data == m_val);
         cadr_pkg::J_LT:     cond = (wb.a_data < m_val);
         default:            cond = 1'b0;                // NEVER
      endcase
   end

   //////////////////////////////
   // Result and jump registers
   //////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         jump_taken <= 1'b0;
      end else if (st_alu) begin
         jump_taken <= (mi.op == cadr_pkg::OP_JUMP) && cond;  // Held into FETCH
      end
   end

   always_ff @(posedge clk) begin
      if (st_alu) begin
         ob_q <= ob;
      end
   end

   // Only ALU and byte ops write back
   assign do_write = st_write &&
                     ((mi.op == cadr_pkg::OP_ALU) || (mi.op == cadr_pkg::OP_BYTE));

   assign wb.wr_en     = do_write;                      // One WRITE cycle wide
   assign wb.wr_dest   = mi.dest;
   assign wb.wr_dest_m = mi.dest_m;
   assign wb.wr_data   = ob_q;

   assign obs_valid  = do_write;                        // Mirrors the write pulse
   assign obs_dest   = mi.dest;
   assign obs_dest_m = mi.dest_m;
   assign obs_data   = ob_q;

endmodule

`default_nettype wire

//--- hdl/cadr_writeback.sv
// A-memory and M-memory scratchpads, registered read ports and write-back
`timescale 1ns/1ps
`default_nettype none

module cadr_writeback (
   input  wire logic  clk,
   input  wire logic  reset,
   cadr_wb_if.store   wb
);

   localparam int A_WORDS = 2**cadr_pkg::AMEM_AW;
   localparam int M_WORDS = 2**cadr_pkg::MMEM_AW;

   logic [cadr_pkg::DATA_W-1:0]  a_mem [0:A_WORDS-1];      // A scratchpad
   logic [cadr_pkg::DATA_W-1:0]  m_mem [0:M_WORDS-1];      // M scratchpad
   logic [cadr_pkg::MMEM_AW-1:0] m_wadr;
   logic [cadr_pkg::AMEM_AW-1:0] a_wadr;

   //////////////////////////////
   // Write addresses
   //////////////////////////////
   assign m_wadr = wb.wr_dest[cadr_pkg::MMEM_AW-1:0];

   // M writes land in the low A words at the same address
   assign a_wadr = wb.wr_dest_m ?
                   {{(cadr_pkg::AMEM_AW - cadr_pkg::MMEM_AW){1'b0}}, m_wadr} :
                   wb.wr_dest;

   //////////////////////////////
   // Write port and clear
   //////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < A_WORDS; i++) begin
            a_mem[i] <= '0;                               // Whole array in one cycle
         end
         for (int j = 0; j < M_WORDS; j++) begin
            m_mem[j] <= '0;
         end
      end else if (wb.wr_en) begin
         a_mem[a_wadr] <= wb.wr_data;
         if (wb.wr_dest_m) begin
            m_mem[m_wadr] <= wb.wr_data;                  // Mirror copy
         end
      end
   end

   //////////////////////////////
   // Read ports
   //////////////////////////////
   // Sampled every cycle, data is good in ALU after READ
   always_ff @(posedge clk) begin
      wb.a_data <= a_mem[wb.rd_aadr];
      wb.m_data <= m_mem[wb.rd_madr];
   end

endmodule

`default_nettype wire

//--- hdl/cadr_top.sv
// Processor top level with sequencer, decode, execute and writeback instances
`timescale 1ns/1ps
`default_nettype none

module cadr_top #(
   parameter int UPC_W = cadr_pkg::UPC_W
) (
   input  wire logic                         clk,
   input  wire logic                         reset,
   input  wire logic                         run,
   input  wire logic                         load_en,
   input  wire logic [UPC_W-1:0]             load_addr,
   input  wire logic [cadr_pkg::UINST_W-1:0] load_data,
   input  wire logic [cadr_pkg::DATA_W-1:0]  md,
   output logic                              obs_valid,
   output logic [cadr_pkg::AMEM_AW-1:0]      obs_dest,
   output logic                              obs_dest_m,
   output logic [cadr_pkg::DATA_W-1:0]       obs_data,
   output logic [UPC_W-1:0]                  upc
);

   cadr_pkg::mstate_t            state;
   logic [cadr_pkg::UINST_W-1:0] uinst;
   logic                         jump_taken;

   cadr_micro_if micro ();                        // Decode to execute
   cadr_wb_if    wb ();                           // Execute to scratchpads

   cadr_sequencer #(.UPC_W(UPC_W)) u_sequencer (
      .clk, .reset, .run, .load_en, .load_addr, .load_data,
      .jump_taken  (jump_taken),
      .jump_target (micro.jump_target[UPC_W-1:0]),  // Low micro-PC bits
      .state       (state),
      .uinst       (uinst),
      .upc         (upc)
   );

   cadr_decode #(.UPC_W(UPC_W)) u_decode (
      .clk, .reset,
      .state (state),
      .uinst (uinst),
      .mi    (micro.producer)
   );

   cadr_execute u_execute (
      .clk, .reset, .state, .md,
      .mi         (micro.consumer),
      .wb         (wb.execute),
      .jump_taken (jump_taken),
      .obs_valid, .obs_dest, .obs_dest_m, .obs_data
   );

   cadr_writeback u_writeback (
      .clk, .reset,
      .wb (wb.store)
   );

endmodule

`default_nettype wire

//--- dv/cadr_tb.sv
// Testbench for cadr_top with program builder, reference model, compare process and timeout
`timescale 1ns/1ps
`default_nettype none

module cadr_tb;

   localparam int UPC_W     = cadr_pkg::UPC_W;
   localparam int PROG_LEN  = 74;                  // 40 ALU, 8 mirror, 12 byte, 13 jump, halt
   localparam int N_EXEC    = 70;                  // Micro-PC changes before halt
   localparam int N_OBS     = 64;                  // Write-back pulses expected
   localparam int HALT_ADDR = PROG_LEN - 1;
   localparam int STALL_MAX = 30;                  // 10 bursts of at most 3 cycles
   localparam int TIMEOUT   = N_EXEC * 5 + PROG_LEN + 5 + 20 + STALL_MAX + 100;

   logic                         clk;
   logic                         reset;
   logic                         run;
   logic                         load_en;
   logic [UPC_W-1:0]             load_addr;
   logic [cadr_pkg::UINST_W-1:0] load_data;
   logic [cadr_pkg::DATA_W-1:0]  md;
   logic                         obs_valid;
   logic [cadr_pkg::AMEM_AW-1:0] obs_dest;
   logic                         obs_dest_m;
   logic [cadr_pkg::DATA_W-1:0]  obs_data;
   logic [UPC_W-1:0]             upc;

   logic [39:0] cm_sh [0:255];                     // Shadow control memory
   logic [31:0] md_tab [0:255];                    // md value per micro-PC
   logic [31:0] a_sh [0:63];
   logic [31:0] m_sh [0:31];
   logic        mirror_rd [0:255];                 // Reads back a mirrored word
   logic [31:0] mirror_exp [0:255];
   int          pg;                                // Builder write pointer
   int          cycle_cnt;
   int          err_data;
   int          err_flow;
   int          n_instr;
   int          n_obs;
   logic [7:0]  exp_pc;
   logic [7:0]  stall_pc;                          // Micro-PC when a stall burst starts
   logic        have_ref;
   logic        obs_seen;
   logic        e_wr;
   logic [31:0] e_res;
   logic [5:0]  e_dst;
   logic        e_dm;
   logic [7:0]  e_npc;

   cadr_top #(.UPC_W(UPC_W)) UUT (
      .clk, .reset, .run, .load_en, .load_addr, .load_data, .md,
      .obs_valid, .obs_dest, .obs_dest_m, .obs_data, .upc
   );

   always #20 clk = ~clk;                           // 40 ns period

   //////////////////////////////
   // Encoding and reference
   //////////////////////////////
   function automatic logic [39:0] encode(input logic [1:0] op, input logic [2:0] aluf,
                                          input logic [1:0] jc, input logic m_is_md,
                                          input logic [4:0] madr, input logic [5:0] aadr,
                                          input logic dest_m, input logic [5:0] dest,
                                          input logic [4:0] rot, input logic [4:0] width);
      logic [39:0] w;
      w = '0;
      w[cadr_pkg::OP_HI:cadr_pkg::OP_LO]       = op;
      w[cadr_pkg::ALUF_HI:cadr_pkg::ALUF_LO]   = aluf;
      w[cadr_pkg::JCOND_HI:cadr_pkg::JCOND_LO] = jc;
      w[cadr_pkg::M_IS_MD_BIT]                 = m_is_md;
      w[cadr_pkg::MADR_HI:cadr_pkg::MADR_LO]   = madr;
      w[cadr_pkg::AADR_HI:cadr_pkg::AADR_LO]   = aadr;
      w[cadr_pkg::DEST_M_BIT]                  = dest_m;
      w[cadr_pkg::DEST_HI:cadr_pkg::DEST_LO]   = dest;
      w[cadr_pkg::ROT_HI:cadr_pkg::ROT_LO]     = rot;
      w[cadr_pkg::WIDTH_HI:cadr_pkg::WIDTH_LO] = width;
      return w;
   endfunction

   // Expected effect of one microinstruction against the shadow scratchpads
   function automatic void ref_step(input logic [39:0] ui, input logic [31:0] mdv,
                                    input logic [7:0] pc, output logic wr,
                                    output logic [31:0] res, output logic [5:0] dst,
                                    output logic dm, output logic [7:0] npc);
      logic [1:0]  op;
      logic [4:0]  r;
      logic [4:0]  w;
      logic [31:0] a;
      logic [31:0] m;
      logic [31:0] rotl;
      logic [63:0] mask;
      logic        taken;
      op   = ui[1:0];
      r    = ui[30:26];
      w    = ui[35:31];
      a    = a_sh[ui[18:13]];
      m    = ui[7] ? mdv : m_sh[ui[12:8]];
      rotl = (r == 0) ? m : ((m << r) | (m >> (32 - int'(r))));
      mask = (64'd1 << (int'(w) + 1)) - 64'd1;      // Low width+1 bits
      case (ui[4:2])
         3'd0:    res = a + m;
         3'd1:    res = a - m;
         3'd2:    res = a & m;
         3'd3:    res = a | m;
         3'd4:    res = a ^ m;
         3'd5:    res = a;
         3'd6:    res = m;
         default: res = m + 32'd1;
      endcase
      if (op == cadr_pkg::OP_BYTE) res = rotl & mask[31:0];
      case (ui[6:5])
         2'd0:    taken = 1'b1;
         2'd1:    taken = (a == m);
         2'd2:    taken = (a < m);
         default: taken = 1'b0;
      endcase
      wr  = (op == cadr_pkg::OP_ALU) || (op == cadr_pkg::OP_BYTE);
      dst = ui[25:20];
      dm  = ui[19];
      npc = (op == cadr_pkg::OP_JUMP && taken) ? ui[27:20] : pc + 8'd1;
   endfunction

   task automatic put(input logic [39:0] word, input logic [31:0] mdv);
      cm_sh[pg]  = word;
      md_tab[pg] = mdv;
      pg++;
   endtask

   task automatic put_jump(input logic [1:0] jc, input logic [31:0] mdv);
      logic [7:0] tgt;
      tgt = pg + 2;                                 // Skips the filler slot
      put(encode(cadr_pkg::OP_JUMP, 3'd0, jc, 1'b1, 5'd0, 6'd60, 1'b0, tgt[5:0],
                 {3'b000, tgt[7:6]}, 5'd0), mdv);
      put(encode(cadr_pkg::OP_ALU, $urandom % 8, 2'd3, 1'b1, $urandom % 32, $urandom % 64,
                 1'b0, $urandom % 32, 5'd0, 5'd0), $urandom);
   endtask

   task automatic build_program;
      logic [4:0]  d;
      logic [31:0] v;
      for (int i = 0; i < 256; i++) begin
         md_tab[i]    = $urandom;
         mirror_rd[i] = 1'b0;
      end
      for (int i = 0; i < 64; i++) a_sh[i] = '0;    // Scratchpads come up clear
      for (int i = 0; i < 32; i++) m_sh[i] = '0;
      pg = 0;
      for (int i = 0; i < 40; i++) begin             // Random ALU ops
         put(encode(cadr_pkg::OP_ALU, $urandom % 8, 2'd3, $urandom % 2, $urandom % 32,
                    $urandom % 64, $urandom % 2, $urandom % 64, 5'd0, 5'd0), $urandom);
      end
      for (int i = 0; i < 4; i++) begin              // M write and read back through A
         d = $urandom % 32;
         put(encode(cadr_pkg::OP_ALU, cadr_pkg::ALU_SETM, 2'd3, 1'b1, 5'd0, 6'd0, 1'b1,
                    {1'b0, d}, 5'd0, 5'd0), $urandom);
         mirror_rd[pg]  = 1'b1;
         mirror_exp[pg] = md_tab[pg-1];
         put(encode(cadr_pkg::OP_ALU, cadr_pkg::ALU_SETA, 2'd3, 1'b0, $urandom % 32,
                    {1'b0, d}, 1'b0, 6'd32 + $urandom % 32, 5'd0, 5'd0), $urandom);
      end
      for (int i = 0; i < 12; i++) begin             // Byte extracts of md
         put(encode(cadr_pkg::OP_BYTE, 3'd0, 2'd3, 1'b1, 5'd0, 6'd0, 1'b0, $urandom % 64,
                    $urandom % 32, $urandom % 32), $urandom);
      end
      v = ($urandom & 32'h7fff_ffff) | 32'h0000_0100;
      put(encode(cadr_pkg::OP_ALU, cadr_pkg::ALU_SETM, 2'd3, 1'b1, 5'd0, 6'd0, 1'b0, 6'd60,
                 5'd0, 5'd0), v);                    // A60 holds the compare value
      put_jump(cadr_pkg::J_ALWAYS, $urandom);
      put_jump(cadr_pkg::J_NEVER, $urandom);
      put_jump(cadr_pkg::J_EQ, v);
      put_jump(cadr_pkg::J_EQ, v ^ 32'd1);
      put_jump(cadr_pkg::J_LT, v + 32'd5);
      put_jump(cadr_pkg::J_LT, v - 32'd1);
      put(encode(cadr_pkg::OP_JUMP, 3'd0, cadr_pkg::J_ALWAYS, 1'b0, 5'd0, 6'd0, 1'b0,
                 HALT_ADDR[5:0], {3'b000, HALT_ADDR[7:6]}, 5'd0), '0);  // Spin here
   endtask

   //////////////////////////////
   // Stimulus
   //////////////////////////////
   always @(negedge clk) begin
      md <= md_tab[upc];                              // Stable through READ and ALU
   end

   initial begin
      $timeformat(-9, 0, "", 0);
      clk       = 1'b0;
      reset     = 1'b1;
      run       = 1'b0;
      load_en   = 1'b0;
      load_addr = '0;
      load_data = '0;
      md        = '0;
      err_data  = 0;
      err_flow  = 0;
      void'($urandom(92));
      cycle_cnt = 0;
      build_program();
      repeat (5) @(negedge clk);
      reset = 1'b0;
      repeat (20) begin                               // Idle with run low
         @(negedge clk);
         assert (!obs_valid && upc == 0) else begin
            err_flow++;
            $display("ERROR at %0t ns: activity while idle, obs_valid %0b upc %0d",
                     $time, obs_valid, upc);
         end
      end
      for (int i = 0; i < PROG_LEN; i++) begin
         @(negedge clk);
         load_en   = 1'b1;
         load_addr = i;
         load_data = cm_sh[i];
      end
      @(negedge clk);
      load_en = 1'b0;
      run     = 1'b1;
      while (upc < 40) @(negedge clk);
      repeat (10) begin                               // Drop run mid-program
         stall_pc = upc;
         while (upc == stall_pc) @(negedge clk);      // Next instruction sits in DECODE
         run = 1'b0;
         repeat (1 + $urandom % 3) @(negedge clk);
         run = 1'b1;
      end
      while (upc != HALT_ADDR) @(negedge clk);
      repeat (10) @(negedge clk);
      run = 1'b0;
      assert (n_instr == N_EXEC && n_obs == N_OBS) else begin
         err_flow++;
         $display("ERROR at %0t ns: %0d instructions and %0d writes, expected %0d and %0d",
                  $time, n_instr, n_obs, N_EXEC, N_OBS);
      end
      $display("Errors: data %0d, flow %0d, total %0d", err_data, err_flow,
               err_data + err_flow);
      if (err_data + err_flow == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   //////////////////////////////
   // Compare process
   //////////////////////////////
   initial begin
      exp_pc   = '0;
      have_ref = 1'b0;
      obs_seen = 1'b0;
      n_instr  = 0;
      n_obs    = 0;
   end

   always @(negedge clk) begin
      if (!reset) begin
         if ((obs_valid || upc != exp_pc) && !have_ref) begin
            ref_step(cm_sh[exp_pc], md_tab[exp_pc], exp_pc, e_wr, e_res, e_dst, e_dm, e_npc);
            have_ref = 1'b1;
         end
         if (obs_valid) begin
            n_obs++;
            assert (e_wr && !obs_seen) else begin
               err_flow++;
               $display("ERROR at %0t ns: unexpected obs_valid at upc %0d", $time, exp_pc);
            end
            assert (obs_data == e_res && obs_dest == e_dst && obs_dest_m == e_dm) else begin
               err_data++;
               $display("ERROR at %0t ns: upc %0d got %h to %0d/%0b, expected %h to %0d/%0b",
                        $time, exp_pc, obs_data, obs_dest, obs_dest_m, e_res, e_dst, e_dm);
            end
            if (mirror_rd[exp_pc]) begin
               assert (obs_data == mirror_exp[exp_pc]) else begin
                  err_data++;
                  $display("ERROR at %0t ns: mirror read %h, expected %h", $time, obs_data,
                           mirror_exp[exp_pc]);
               end
            end
            if (e_dm) begin                           // M word and its A copy
               m_sh[e_dst[4:0]]          = e_res;
               a_sh[{1'b0, e_dst[4:0]}] = e_res;
            end else begin
               a_sh[e_dst] = e_res;
            end
            obs_seen = 1'b1;
         end
         if (upc != exp_pc) begin
            n_instr++;
            assert (upc == e_npc) else begin
               err_flow++;
               $display("ERROR at %0t ns: upc %0d after %0d, expected %0d", $time, upc,
                        exp_pc, e_npc);
            end
            assert (obs_seen == e_wr) else begin
               err_flow++;
               $display("ERROR at %0t ns: missing write for upc %0d", $time, exp_pc);
            end
            exp_pc   = upc;                           // Resync on the DUT
            have_ref = 1'b0;
            obs_seen = 1'b0;
         end
      end
   end

   //////////////////////////////
   // Timeout
   //////////////////////////////
   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT) begin
         $display("Timeout after %0d cycles, the program never reached its halt loop",
                  TIMEOUT);
         $display("Simulation failed");
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- flist.f
hdl/cadr_pkg.sv
hdl/cadr_micro_if.sv
hdl/cadr_wb_if.sv
hdl/cadr_sequencer.sv
hdl/cadr_decode.sv
hdl/cadr_execute.sv
hdl/cadr_writeback.sv
hdl/cadr_top.sv
dv/cadr_tb.sv
